/* build.f */
+incdir+.
miu_pkg.sv
miu_req_arbiter.sv
miu_lane_sequencer.sv
miu_resp_tracker.sv
miu_top.sv
tb_miu.sv

/* miu_defines.svh */
`ifndef MIU_DEFINES_SVH
`define MIU_DEFINES_SVH

// Address and data widths
`define MIU_ADDR_W      32
`define MIU_WORD_W      32
`define MIU_LINE_W      128

// Vector split into word lanes
`define MIU_LANES       4

// Address step between lanes in unit-stride mode
`define MIU_LANE_BYTES  4

// Destination register tag
`define MIU_RD_W        5

// Outstanding loads the tracker can hold
`define MIU_PEND_DEPTH  8

`endif

/* miu_lane_sequencer.sv */
`timescale 1ns/1ps
`include "miu_defines.svh"

module miu_lane_sequencer import miu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      req_valid,
    input  mem_req_t  req,
    output logic      req_ready,

    input  vec_mode_e vec_mode,
    input  addr_t     vec_stride,

    output logic      gbl_valid,
    output gbl_req_t  gbl_req,
    input  logic      gbl_ready,

    output logic      seq_busy
);

    seq_state_e state_q;
    seq_state_e state_d;

    // Held vector request for lanes 1 to 3
    addr_t      base_q;
    line_t      line_q;
    reg_idx_t   rd_q;
    logic       tex_q;

    lane_idx_t  cur_lane;
    logic       cur_load;
    logic       unit_step;

    function automatic addr_t lane_addr(addr_t base, lane_idx_t lane, logic unit,
                                        addr_t stride);
        addr_t step;
        step = unit ? addr_t'(`MIU_LANE_BYTES) : stride;
        return base + addr_t'(lane) * step;
    endfunction

    function automatic word_t lane_word(line_t line, lane_idx_t lane);
        return line[lane*`MIU_WORD_W +: `MIU_WORD_W];
    endfunction

    assign req_ready = (state_q == SEQ_IDLE) && gbl_ready;
    assign seq_busy  = (state_q != SEQ_IDLE);

    // Texture refills always walk unit stride
    assign unit_step = tex_q || (vec_mode == VEC_UNIT);

    always_comb begin
        cur_lane = '0;
        cur_load = 1'b0;
        case (state_q)
            SEQ_WR1: cur_lane = 2'd1;
            SEQ_WR2: cur_lane = 2'd2;
            SEQ_WR3: cur_lane = 2'd3;
            SEQ_RD1: begin
                cur_lane = 2'd1;
                cur_load = 1'b1;
            end
            SEQ_RD2: begin
                cur_lane = 2'd2;
                cur_load = 1'b1;
            end
            SEQ_RD3: begin
                cur_lane = 2'd3;
                cur_load = 1'b1;
            end
            default: ;
        endcase
    end

    // --------------------
    // Global beat drive
    always_comb begin
        if (state_q == SEQ_IDLE) begin
            // Scalar, or lane 0 of a vector, goes straight out
            gbl_valid       = req_valid;
            gbl_req.is_load = req.is_load;
            gbl_req.addr    = req.addr;
            gbl_req.wdata   = lane_word(req.wdata, '0);
            gbl_req.rd      = req.rd;
        end else begin
            gbl_valid       = 1'b1;
            gbl_req.is_load = cur_load;
            gbl_req.addr    = lane_addr(base_q, cur_lane, unit_step, vec_stride);
            gbl_req.wdata   = lane_word(line_q, cur_lane);
            gbl_req.rd      = rd_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (req_valid && req_ready && req.is_vector) begin
                    state_d = req.is_load ? SEQ_RD1 : SEQ_WR1;
                end
            end
            SEQ_WR1: if (gbl_ready) state_d = SEQ_WR2;
            SEQ_WR2: if (gbl_ready) state_d = SEQ_WR3;
            SEQ_WR3: if (gbl_ready) state_d = SEQ_IDLE;
            SEQ_RD1: if (gbl_ready) state_d = SEQ_RD2;
            SEQ_RD2: if (gbl_ready) state_d = SEQ_RD3;
            SEQ_RD3: if (gbl_ready) state_d = SEQ_IDLE;
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SEQ_IDLE && req_valid && req_ready && req.is_vector) begin
            base_q <= req.addr;
            line_q <= req.wdata;
            rd_q   <= req.rd;
            tex_q  <= req.is_tex;
        end
    end

endmodule

/* miu_pkg.sv */
`include "miu_defines.svh"

package miu_pkg;

    typedef logic [`MIU_ADDR_W-1:0]         addr_t;
    typedef logic [`MIU_WORD_W-1:0]         word_t;
    typedef logic [`MIU_LINE_W-1:0]         line_t;
    typedef logic [`MIU_RD_W-1:0]           reg_idx_t;
    typedef logic [$clog2(`MIU_LANES)-1:0]  lane_idx_t;

    // Requesters, highest priority first
    typedef enum logic [1:0] {
        SRC_LSU,
        SRC_WMB,
        SRC_TEX
    } src_e;

    typedef enum logic {
        VEC_UNIT,
        VEC_STRIDED
    } vec_mode_e;

    // Idle, then the three trailing lanes of a vector store or load
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_WR1,
        SEQ_WR2,
        SEQ_WR3,
        SEQ_RD1,
        SEQ_RD2,
        SEQ_RD3
    } seq_state_e;

    // Normalized request after arbitration
    typedef struct packed {
        logic     is_load;
        logic     is_vector;
        logic     is_tex;
        addr_t    addr;
        line_t    wdata;
        reg_idx_t rd;
    } mem_req_t;

    // One beat on the 32-bit global port
    typedef struct packed {
        logic     is_load;
        addr_t    addr;
        word_t    wdata;
        reg_idx_t rd;
    } gbl_req_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
    } gbl_resp_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data_scalar;
        line_t    data_vector;
        logic     is_vector;
        logic     is_tex;
    } miu_resp_t;

endpackage

/* miu_req_arbiter.sv */
`timescale 1ns/1ps

module miu_req_arbiter import miu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     lsu_valid,
    input  mem_req_t lsu_req,
    output logic     lsu_ready,

    input  logic     wmb_valid,
    input  addr_t    wmb_addr,
    input  word_t    wmb_wdata,
    output logic     wmb_ready,

    input  logic     tex_valid,
    input  addr_t    tex_addr,
    output logic     tex_ready,

    input  logic     pend_full,
    input  logic     tex_done,
    input  logic     req_ready,
    output logic     req_valid,
    output mem_req_t req
);

    logic tex_inflight;
    logic lsu_elig;
    logic tex_elig;
    src_e grant_src;

    // Loads wait while the pending queue is full
    assign lsu_elig = lsu_valid && !(lsu_req.is_load && pend_full);
    assign tex_elig = tex_valid && !tex_inflight && !pend_full;

    // --------------------
    // Fixed priority LSU > WMB > texture
    always_comb begin
        req_valid = 1'b1;
        grant_src = SRC_LSU;
        req       = lsu_req;
        req.is_tex = 1'b0;
        if (lsu_elig) begin
            grant_src = SRC_LSU;
        end else if (wmb_valid) begin
            grant_src     = SRC_WMB;
            req.is_load   = 1'b0;
            req.is_vector = 1'b0;
            req.addr      = wmb_addr;
            req.wdata     = line_t'(wmb_wdata);
            req.rd        = '0;
        end else if (tex_elig) begin
            grant_src     = SRC_TEX;
            req.is_load   = 1'b1;
            req.is_vector = 1'b1;
            req.is_tex    = 1'b1;
            req.addr      = tex_addr;
            req.wdata     = '0;
            req.rd        = '0;
        end else begin
            req_valid = 1'b0;
        end
    end

    assign lsu_ready = req_valid && req_ready && (grant_src == SRC_LSU);
    assign wmb_ready = req_valid && req_ready && (grant_src == SRC_WMB);
    assign tex_ready = req_valid && req_ready && (grant_src == SRC_TEX);

    // One texture refill in flight, released when its line completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tex_inflight <= 1'b0;
        end else if (tex_valid && tex_ready) begin
            tex_inflight <= 1'b1;
        end else if (tex_done) begin
            tex_inflight <= 1'b0;
        end
    end

endmodule

/* miu_resp_tracker.sv */
`timescale 1ns/1ps
`include "miu_defines.svh"

module miu_resp_tracker import miu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      acc_valid,
    input  mem_req_t  acc_req,

    input  logic      gbl_resp_valid,
    input  gbl_resp_t gbl_resp,

    output logic      pend_full,
    output logic      pend_empty,

    output logic      resp_valid,
    output miu_resp_t resp,

    output logic      tex_done
);

    localparam int PTR_W = $clog2(`MIU_PEND_DEPTH);

    // --------------------
    // Pending-load queue, one entry per accepted load
    logic pend_vec [`MIU_PEND_DEPTH];
    logic pend_tex [`MIU_PEND_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;

    logic push;
    logic pop;
    logic resp_hit;
    logic head_vec;
    logic head_tex;

    // Lane collector for vector loads
    lane_idx_t lane_cnt_q;
    line_t     buf_q;
    reg_idx_t  rd_q;

    assign push       = acc_valid && acc_req.is_load;
    assign pend_empty = (count_q == '0);
    assign pend_full  = (count_q == (PTR_W+1)'(`MIU_PEND_DEPTH));

    assign head_vec = pend_vec[rd_ptr_q];
    assign head_tex = pend_tex[rd_ptr_q];

    // Stray responses with nothing pending are dropped
    assign resp_hit = gbl_resp_valid && !pend_empty;
    assign pop      = resp_hit &&
                      (!head_vec || lane_cnt_q == lane_idx_t'(`MIU_LANES - 1));

    always_ff @(posedge clk) begin
        if (push) begin
            pend_vec[wr_ptr_q] <= acc_req.is_vector;
            pend_tex[wr_ptr_q] <= acc_req.is_tex;
        end
    end

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // --------------------
    // Lane gathering
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_cnt_q <= '0;
        end else if (resp_hit && head_vec) begin
            lane_cnt_q <= lane_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (resp_hit && head_vec) begin
            buf_q[lane_cnt_q*`MIU_WORD_W +: `MIU_WORD_W] <= gbl_resp.data;
            // The tag of the first lane names the whole line
            if (lane_cnt_q == '0) rd_q <= gbl_resp.rd;
        end
    end

    // Last lane bypasses the buffer so the line leaves with its fourth beat
    always_comb begin
        resp.rd          = head_vec ? rd_q : gbl_resp.rd;
        resp.data_scalar = gbl_resp.data;
        resp.data_vector = {gbl_resp.data, buf_q[`MIU_LINE_W-`MIU_WORD_W-1:0]};
        resp.is_vector   = head_vec;
        resp.is_tex      = head_tex;
    end

    assign resp_valid = pop;
    assign tex_done   = pop && head_tex;

endmodule

/* miu_top.sv */
`timescale 1ns/1ps

module miu_top import miu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  logic      lsu_valid,
    input  mem_req_t  lsu_req,
    output logic      lsu_ready,

    input  logic      wmb_valid,
    input  addr_t     wmb_addr,
    input  word_t     wmb_wdata,
    output logic      wmb_ready,

    input  logic      tex_valid,
    input  addr_t     tex_addr,
    output logic      tex_ready,

    input  vec_mode_e vec_mode,
    input  addr_t     vec_stride,

    output logic      gbl_valid,
    output gbl_req_t  gbl_req,
    input  logic      gbl_ready,
    input  logic      gbl_resp_valid,
    input  gbl_resp_t gbl_resp,

    output logic      resp_valid,
    output miu_resp_t resp,
    output logic      tex_resp_valid,
    output line_t     tex_resp_data,

    output logic      busy
);

    logic     req_valid;
    logic     req_ready;
    mem_req_t req;
    logic     acc_valid;
    logic     seq_busy;
    logic     pend_full;
    logic     pend_empty;
    logic     tex_done;

    assign acc_valid = req_valid && req_ready;

    miu_req_arbiter i_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsu_valid (lsu_valid),
        .lsu_req   (lsu_req),
        .lsu_ready (lsu_ready),
        .wmb_valid (wmb_valid),
        .wmb_addr  (wmb_addr),
        .wmb_wdata (wmb_wdata),
        .wmb_ready (wmb_ready),
        .tex_valid (tex_valid),
        .tex_addr  (tex_addr),
        .tex_ready (tex_ready),
        .pend_full (pend_full),
        .tex_done  (tex_done),
        .req_ready (req_ready),
        .req_valid (req_valid),
        .req       (req)
    );

    miu_lane_sequencer i_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .vec_mode   (vec_mode),
        .vec_stride (vec_stride),
        .gbl_valid  (gbl_valid),
        .gbl_req    (gbl_req),
        .gbl_ready  (gbl_ready),
        .seq_busy   (seq_busy)
    );

    miu_resp_tracker i_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .acc_valid      (acc_valid),
        .acc_req        (req),
        .gbl_resp_valid (gbl_resp_valid),
        .gbl_resp       (gbl_resp),
        .pend_full      (pend_full),
        .pend_empty     (pend_empty),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .tex_done       (tex_done)
    );

    // Texture port mirrors the shared response
    assign tex_resp_valid = resp_valid && resp.is_tex;
    assign tex_resp_data  = resp.data_vector;

    assign busy = seq_busy || (req_valid && !req_ready) || !pend_empty;

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the MIU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_miu \
    -Mdir obj_dir -o tb_miu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_miu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* tb_miu.sv */
`timescale 1ns/1ps
`include "miu_defines.svh"

module tb_miu import miu_pkg::*; ();

    localparam int MAX_CYCLES = 3000;
    localparam int LANES      = `MIU_LANES;
    localparam int WORD_W     = `MIU_WORD_W;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      lsu_valid;
    mem_req_t  lsu_req;
    logic      lsu_ready;
    logic      wmb_valid;
    addr_t     wmb_addr;
    word_t     wmb_wdata;
    logic      wmb_ready;
    logic      tex_valid;
    addr_t     tex_addr;
    logic      tex_ready;
    vec_mode_e vec_mode;
    addr_t     vec_stride;
    logic      gbl_valid;
    gbl_req_t  gbl_req;
    logic      gbl_ready = 1'b1;
    logic      gbl_resp_valid = 1'b0;
    gbl_resp_t gbl_resp = '0;
    logic      resp_valid;
    miu_resp_t resp;
    logic      tex_resp_valid;
    line_t     tex_resp_data;
    logic      busy;

    // Observed and expected traffic
    gbl_req_t  beats[$];
    gbl_req_t  exp_beats[$];
    miu_resp_t got_resp[$];
    miu_resp_t exp_resp[$];
    line_t     tex_lines[$];
    line_t     exp_tex[$];

    // Loads waiting for the memory model to answer
    addr_t     ld_addr[$];
    reg_idx_t  ld_rd[$];

    int        cycle_cnt = 0;
    int        gap = 0;
    logic      bp_en = 1'b0;
    addr_t     lane_step = 32'd4;

    miu_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .lsu_valid      (lsu_valid),
        .lsu_req        (lsu_req),
        .lsu_ready      (lsu_ready),
        .wmb_valid      (wmb_valid),
        .wmb_addr       (wmb_addr),
        .wmb_wdata      (wmb_wdata),
        .wmb_ready      (wmb_ready),
        .tex_valid      (tex_valid),
        .tex_addr       (tex_addr),
        .tex_ready      (tex_ready),
        .vec_mode       (vec_mode),
        .vec_stride     (vec_stride),
        .gbl_valid      (gbl_valid),
        .gbl_req        (gbl_req),
        .gbl_ready      (gbl_ready),
        .gbl_resp_valid (gbl_resp_valid),
        .gbl_resp       (gbl_resp),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .tex_resp_valid (tex_resp_valid),
        .tex_resp_data  (tex_resp_data),
        .busy           (busy)
    );

    always #2 clk = ~clk;

    // --------------------
    // Error handling and compare tasks
    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_rd(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // --------------------
    // Memory model
    function automatic word_t mem_word(addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic line_t mem_line(addr_t base, addr_t step);
        line_t l;
        for (int k = 0; k < LANES; k++) begin
            l[k*WORD_W +: WORD_W] = mem_word(base + addr_t'(k) * step);
        end
        return l;
    endfunction

    // Loads are answered in order, each after 0 to 3 idle cycles
    always @(posedge clk) begin
        gbl_ready      <= bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
        gbl_resp_valid <= 1'b0;
        if (ld_addr.size() > 0) begin
            if (gap > 0) begin
                gap = gap - 1;
            end else begin
                gbl_resp_valid <= 1'b1;
                gbl_resp.rd    <= ld_rd.pop_front();
                gbl_resp.data  <= mem_word(ld_addr.pop_front());
                gap = $urandom_range(0, 3);
            end
        end
    end

    // Beats are logged mid-cycle and transfer on the next edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (gbl_valid && gbl_ready) begin
                beats.push_back(gbl_req);
                if (gbl_req.is_load) begin
                    ld_addr.push_back(gbl_req.addr);
                    ld_rd.push_back(gbl_req.rd);
                end
            end
            if (resp_valid) got_resp.push_back(resp);
            if (tex_resp_valid) tex_lines.push_back(tex_resp_data);
            if (!gbl_ready && (lsu_ready || wmb_ready || tex_ready)) begin
                $display("Requester ready given at %0t while global ready is low", $time);
                abort_run();
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            abort_run();
        end
    end

    // --------------------
    // Expected traffic
    task automatic expect_lsu(logic ld, logic vec, addr_t a, line_t d, reg_idx_t rd);
        gbl_req_t  b;
        miu_resp_t r;
        int        n;
        n = vec ? LANES : 1;
        for (int k = 0; k < n; k++) begin
            b.is_load = ld;
            b.addr    = a + addr_t'(k) * lane_step;
            b.wdata   = d[k*WORD_W +: WORD_W];
            b.rd      = rd;
            exp_beats.push_back(b);
        end
        if (ld) begin
            r.rd          = rd;
            r.data_scalar = mem_word(a);
            r.data_vector = mem_line(a, lane_step);
            r.is_vector   = vec;
            r.is_tex      = 1'b0;
            exp_resp.push_back(r);
        end
    endtask

    task automatic expect_wmb(addr_t a, word_t w);
        gbl_req_t b;
        b.is_load = 1'b0;
        b.addr    = a;
        b.wdata   = w;
        b.rd      = '0;
        exp_beats.push_back(b);
    endtask

    // Texture refills always walk unit stride
    task automatic expect_tex(addr_t a);
        gbl_req_t  b;
        miu_resp_t r;
        for (int k = 0; k < LANES; k++) begin
            b.is_load = 1'b1;
            b.addr    = a + addr_t'(k * `MIU_LANE_BYTES);
            b.wdata   = '0;
            b.rd      = '0;
            exp_beats.push_back(b);
        end
        r.rd          = '0;
        r.data_scalar = '0;
        r.data_vector = mem_line(a, addr_t'(`MIU_LANE_BYTES));
        r.is_vector   = 1'b1;
        r.is_tex      = 1'b1;
        exp_resp.push_back(r);
        exp_tex.push_back(r.data_vector);
    endtask

    // --------------------
    // Requester handshakes
    task automatic lsu_handshake(mem_req_t r);
        @(posedge clk);
        lsu_valid <= 1'b1;
        lsu_req   <= r;
        @(negedge clk);
        while (!lsu_ready) @(negedge clk);
        @(posedge clk);
        lsu_valid <= 1'b0;
    endtask

    task automatic wmb_handshake(addr_t a, word_t w);
        @(posedge clk);
        wmb_valid <= 1'b1;
        wmb_addr  <= a;
        wmb_wdata <= w;
        @(negedge clk);
        while (!wmb_ready) @(negedge clk);
        @(posedge clk);
        wmb_valid <= 1'b0;
    endtask

    task automatic tex_handshake(addr_t a);
        @(posedge clk);
        tex_valid <= 1'b1;
        tex_addr  <= a;
        @(negedge clk);
        while (!tex_ready) @(negedge clk);
        @(posedge clk);
        tex_valid <= 1'b0;
    endtask

    function automatic mem_req_t build_lsu_req(logic ld, logic vec, addr_t a, line_t d,
                                               reg_idx_t rd);
        mem_req_t r;
        r.is_load   = ld;
        r.is_vector = vec;
        r.is_tex    = 1'b0;
        r.addr      = a;
        r.wdata     = d;
        r.rd        = rd;
        return r;
    endfunction

    task automatic lsu_op(logic ld, logic vec, addr_t a, line_t d, reg_idx_t rd);
        expect_lsu(ld, vec, a, d, rd);
        lsu_handshake(build_lsu_req(ld, vec, a, d, rd));
    endtask

    // Only called while the sequencer is idle
    task automatic set_mode(vec_mode_e m, addr_t stride);
        @(posedge clk);
        vec_mode   <= m;
        vec_stride <= stride;
        lane_step = (m == VEC_UNIT) ? addr_t'(`MIU_LANE_BYTES) : stride;
    endtask

    task automatic compare_traffic();
        gbl_req_t  gb;
        gbl_req_t  eb;
        miu_resp_t gr;
        miu_resp_t er;
        if (beats.size() != exp_beats.size() || got_resp.size() != exp_resp.size() ||
            tex_lines.size() != exp_tex.size()) begin
            $display("Traffic count wrong: %0d beats, %0d responses, %0d texture lines",
                     beats.size(), got_resp.size(), tex_lines.size());
            abort_run();
        end
        while (exp_beats.size() > 0) begin
            gb = beats.pop_front();
            eb = exp_beats.pop_front();
            check_flag("gbl_req.is_load", gb.is_load, eb.is_load);
            check_addr("gbl_req.addr", gb.addr, eb.addr);
            check_rd("gbl_req.rd", gb.rd, eb.rd);
            if (!eb.is_load) check_word("gbl_req.wdata", gb.wdata, eb.wdata);
        end
        while (exp_resp.size() > 0) begin
            gr = got_resp.pop_front();
            er = exp_resp.pop_front();
            check_flag("resp.is_vector", gr.is_vector, er.is_vector);
            check_flag("resp.is_tex", gr.is_tex, er.is_tex);
            check_rd("resp.rd", gr.rd, er.rd);
            if (er.is_vector) begin
                check_line("resp.data_vector", gr.data_vector, er.data_vector);
            end else begin
                check_word("resp.data_scalar", gr.data_scalar, er.data_scalar);
            end
        end
        while (exp_tex.size() > 0) begin
            check_line("tex_resp_data", tex_lines.pop_front(), exp_tex.pop_front());
        end
    endtask

    // Busy holds while traffic is outstanding and drops once it has drained
    task automatic drain_and_compare();
        while (beats.size() < exp_beats.size() || got_resp.size() < exp_resp.size()) begin
            @(negedge clk);
            if (beats.size() < exp_beats.size() || got_resp.size() < exp_resp.size()) begin
                check_flag("busy", busy, 1'b1);
            end
        end
        repeat (2) @(negedge clk);
        check_flag("busy", busy, 1'b0);
        compare_traffic();
    endtask

    // --------------------
    // Directed tests
    task automatic scalar_store_load();
        lsu_op(1'b0, 1'b0, 32'h0000_0100, 128'h1111_2222_3333_4444_5555_6666_dead_beef, 5'd0);
        lsu_op(1'b1, 1'b0, 32'h0000_0200, '0, 5'd7);
        drain_and_compare();
    endtask

    task automatic unit_vector_ops();
        lsu_op(1'b0, 1'b1, 32'h0000_1000, 128'hA0A0_0003_B1B1_0002_C2C2_0001_D3D3_0000, 5'd4);
        lsu_op(1'b1, 1'b1, 32'h0000_2000, '0, 5'd12);
        drain_and_compare();
    endtask

    task automatic strided_vector_ops();
        set_mode(VEC_STRIDED, 32'h40);
        lsu_op(1'b0, 1'b1, 32'h0000_3000, 128'h0bad_0003_0bad_0002_0bad_0001_0bad_0000, 5'd1);
        lsu_op(1'b1, 1'b1, 32'h0000_5000, '0, 5'd9);
        drain_and_compare();
        set_mode(VEC_UNIT, '0);
    endtask

    task automatic priority_order();
        mem_req_t r;
        r = build_lsu_req(1'b0, 1'b0, 32'h0000_0600, 128'h0000_0000_0000_0000_0000_0000_0123_4567,
                          5'd2);
        expect_lsu(r.is_load, r.is_vector, r.addr, r.wdata, r.rd);
        expect_wmb(32'h0000_0700, 32'hcafe_f00d);
        expect_tex(32'h0000_0800);
        fork
            lsu_handshake(r);
            wmb_handshake(32'h0000_0700, 32'hcafe_f00d);
            tex_handshake(32'h0000_0800);
        join
        drain_and_compare();
    endtask

    // Second refill stays valid and must wait for the first line
    // Strided mode is selected so the refills still have to walk unit stride
    task automatic texture_refill();
        logic first_done;
        set_mode(VEC_STRIDED, 32'h40);
        expect_tex(32'h0000_9000);
        expect_tex(32'h0000_a000);
        first_done = 1'b0;
        @(posedge clk);
        tex_valid <= 1'b1;
        tex_addr  <= 32'h0000_9000;
        @(negedge clk);
        while (!tex_ready) @(negedge clk);
        @(posedge clk);
        tex_addr <= 32'h0000_a000;
        @(negedge clk);
        while (!tex_ready) begin
            if (tex_resp_valid) first_done = 1'b1;
            @(negedge clk);
        end
        if (!first_done) begin
            $display("Second texture refill granted at %0t before the first completed", $time);
            abort_run();
        end
        @(posedge clk);
        tex_valid <= 1'b0;
        drain_and_compare();
        set_mode(VEC_UNIT, '0);
    endtask

    task automatic backpressure_mix();
        int       i;
        int       kind;
        addr_t    a;
        line_t    d;
        reg_idx_t rd;
        bp_en = 1'b1;
        for (i = 0; i < 12; i++) begin
            kind = $urandom_range(0, 4);
            a    = addr_t'($urandom_range(0, 1023)) << 4;
            d    = {$urandom, $urandom, $urandom, $urandom};
            rd   = reg_idx_t'($urandom_range(1, 31));
            case (kind)
                0: lsu_op(1'b0, 1'b0, a, d, rd);
                1: lsu_op(1'b1, 1'b0, a, d, rd);
                2: lsu_op(1'b0, 1'b1, a, d, rd);
                3: lsu_op(1'b1, 1'b1, a, d, rd);
                default: begin
                    expect_wmb(a, d[WORD_W-1:0]);
                    wmb_handshake(a, d[WORD_W-1:0]);
                end
            endcase
        end
        drain_and_compare();
        bp_en = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h40c02301));
        rst_n      = 1'b0;
        lsu_valid  = 1'b0;
        lsu_req    = '0;
        wmb_valid  = 1'b0;
        wmb_addr   = '0;
        wmb_wdata  = '0;
        tex_valid  = 1'b0;
        tex_addr   = '0;
        vec_mode   = VEC_UNIT;
        vec_stride = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Quiet outputs straight after reset
        @(negedge clk);
        check_flag("gbl_valid", gbl_valid, 1'b0);
        check_flag("resp_valid", resp_valid, 1'b0);
        check_flag("tex_resp_valid", tex_resp_valid, 1'b0);
        check_flag("lsu_ready", lsu_ready, 1'b0);
        check_flag("wmb_ready", wmb_ready, 1'b0);
        check_flag("tex_ready", tex_ready, 1'b0);
        check_flag("busy", busy, 1'b0);

        scalar_store_load();
        unit_vector_ops();
        strided_vector_ops();
        priority_order();
        texture_refill();
        backpressure_mix();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
